/* logic/bridge_macros.svh */
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// bus and map sizing
`define WIDTH           32
`define SLAVES          4
`define CFG_TOP         8       // config window is 0 to CFG_TOP

// slave windows out of reset
`define SLAVE1_BASE     'h8000_0000
`define SLAVE2_BASE     'h8400_0000
`define SLAVE3_BASE     'h8800_0000
`define SLAVE4_BASE     'h8C00_0000
`define SLAVE_LEN       'h0000_03FF

`endif

/* logic/ahb_pkg.sv */
`include "bridge_macros.svh"

package ahb_pkg;

        typedef logic [`WIDTH-1:0] word_t;      // address or data word

        typedef enum logic [1:0]
        {
                IDLE   = 2'b00,
                BUSY   = 2'b01,
                NONSEQ = 2'b10,
                SEQ    = 2'b11
        } htrans_t;

        // transfer is 8 << size bits wide
        typedef logic [2:0] hsize_t;

        typedef enum logic [1:0]
        {
                OKAY  = 2'b00,
                ERROR = 2'b10
        } hresp_t;

endpackage

/* logic/bridge_cfg_pkg.sv */
`include "bridge_macros.svh"

package bridge_cfg_pkg;

        // one-hot APB slave select unless windows overlap
        typedef logic [`SLAVES-1:0] slave_sel_t;

        // odd index is a base and even index a length
        typedef logic [3:0] cfg_index_t;

endpackage

/* logic/cfg_regfile.sv */
`include "bridge_macros.svh"

module cfg_regfile
(
        input  logic                            Hclk,
        input  logic                            Hresetn,
        input  ahb_pkg::htrans_t                Htrans,
        input  logic                            Hreadyin,
        input  logic                            Hwrite,
        input  ahb_pkg::word_t                  Haddr,
        input  ahb_pkg::word_t                  Hwdata,
        input  ahb_pkg::hresp_t                 Hresp,
        output ahb_pkg::word_t [`SLAVES-1:0]    base,
        output ahb_pkg::word_t [`SLAVES-1:0]    len,
        output ahb_pkg::word_t                  config_reg_data
);

        logic                           addr_phase;
        logic                           cfg_hit;
        logic                           wr_pend;
        logic                           wr_en;
        bridge_cfg_pkg::cfg_index_t     wr_idx;
        bridge_cfg_pkg::cfg_index_t     rd_idx;
        ahb_pkg::word_t                 rd_word;

        assign addr_phase = Hreadyin && (Htrans == ahb_pkg::NONSEQ || Htrans == ahb_pkg::SEQ);
        assign cfg_hit    = (Haddr <= `CFG_TOP);
        assign rd_idx     = bridge_cfg_pkg::cfg_index_t'(Haddr[3:0]);
        assign wr_en      = wr_pend && (Hresp != ahb_pkg::ERROR);

        // capture config write from the address phase
        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                begin
                        wr_pend <= 1'b0;
                        wr_idx  <= '0;
                end
                else
                begin
                        wr_pend <= addr_phase && Hwrite && cfg_hit;
                        wr_idx  <= rd_idx;
                end
        end

        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                begin
                        base[0] <= `SLAVE1_BASE;
                        base[1] <= `SLAVE2_BASE;
                        base[2] <= `SLAVE3_BASE;
                        base[3] <= `SLAVE4_BASE;
                        for (int i = 0; i < `SLAVES; i++)
                                len[i] <= `SLAVE_LEN;
                end
                else if (wr_en)
                begin
                        // index 0 matches nothing so its writes drop
                        for (int i = 0; i < `SLAVES; i++)
                        begin
                                if (wr_idx == bridge_cfg_pkg::cfg_index_t'(2 * i + 1))
                                        base[i] <= Hwdata;
                                if (wr_idx == bridge_cfg_pkg::cfg_index_t'(2 * i + 2))
                                        len[i] <= Hwdata;
                        end
                end
        end

        always_comb
        begin
                rd_word = '0;
                for (int i = 0; i < `SLAVES; i++)
                begin
                        if (rd_idx == bridge_cfg_pkg::cfg_index_t'(2 * i + 1))
                                rd_word = base[i];
                        if (rd_idx == bridge_cfg_pkg::cfg_index_t'(2 * i + 2))
                                rd_word = len[i];
                end
                if (!cfg_hit)
                        rd_word = '0;
                else if (wr_en && wr_idx == rd_idx && rd_idx != '0)
                        rd_word = Hwdata;       // read right behind a write
        end

        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                        config_reg_data <= '0;
                else if (Hreadyin)
                        config_reg_data <= (addr_phase && !Hwrite) ? rd_word : '0;
        end

        // an errored data phase leaves the whole map as it was
        a_no_write_on_error: assert property (@(posedge Hclk) disable iff (!Hresetn)
                (Hresp == ahb_pkg::ERROR) |=> ($stable(base) && $stable(len)));

endmodule

/* logic/slave_decoder.sv */
`include "bridge_macros.svh"

module slave_decoder
(
        input  ahb_pkg::word_t                  Haddr,
        input  ahb_pkg::word_t [`SLAVES-1:0]    base,
        input  ahb_pkg::word_t [`SLAVES-1:0]    len,
        output bridge_cfg_pkg::slave_sel_t      Pselx_out
);

        logic [`WIDTH:0]        win_end;
        logic                   bases_high;

        // every window checked on its own so overlaps give several bits
        always_comb
        begin
                Pselx_out  = '0;
                bases_high = 1'b1;
                win_end    = '0;
                for (int i = 0; i < `SLAVES; i++)
                begin
                        win_end      = {1'b0, base[i]} + {1'b0, len[i]};   // carry kept
                        Pselx_out[i] = (Haddr >= base[i]) && ({1'b0, Haddr} < win_end);
                        if (base[i] <= `CFG_TOP)
                                bases_high = 1'b0;
                end
                if (bases_high && Haddr <= `CFG_TOP)
                begin
                        assert (Pselx_out == '0)
                        else
                                $error("slave select 0x%0h on config address 0x%0h",
                                       Pselx_out, Haddr);
                end
        end

endmodule

/* logic/transfer_checker.sv */
`include "bridge_macros.svh"

module transfer_checker
(
        input  logic                    Hclk,
        input  logic                    Hresetn,
        input  ahb_pkg::htrans_t        Htrans,
        input  ahb_pkg::hsize_t         Hsize,
        input  logic                    Hwrite,
        input  ahb_pkg::word_t          Haddr,
        input  logic                    Hreadyin,
        output ahb_pkg::hresp_t         Hresp,
        output logic                    err_stall
);

        typedef enum logic [1:0]
        {
                ERR_IDLE   = 2'b00,
                ERR_FIRST  = 2'b01,     // ERROR with Hreadyout low
                ERR_SECOND = 2'b10      // ERROR with Hreadyout high
        } err_state_t;

        err_state_t             state;
        err_state_t             state_nxt;
        ahb_pkg::htrans_t       htrans_prev;
        ahb_pkg::hsize_t        hsize_prev;
        logic                   hwrite_prev;
        logic                   addr_phase;
        ahb_pkg::word_t         align_mask;
        logic                   misaligned;
        logic                   oversize;
        logic                   seq_after_idle;
        logic                   seq_mismatch;
        logic                   error;

        assign addr_phase = Hreadyin && (Htrans == ahb_pkg::NONSEQ || Htrans == ahb_pkg::SEQ);

        // low Hsize address bits must be clear outside the config window
        assign align_mask = ~({`WIDTH{1'b1}} << Hsize);
        assign misaligned = (Haddr > `CFG_TOP) && ((Haddr & align_mask) != '0);

        assign oversize = ((32'd8 << Hsize) > `WIDTH);

        assign seq_after_idle = (Htrans == ahb_pkg::SEQ) && (htrans_prev == ahb_pkg::IDLE);

        // burst beats keep size and direction
        assign seq_mismatch = (Htrans == ahb_pkg::SEQ) && (htrans_prev == ahb_pkg::NONSEQ) &&
                              ((Hsize != hsize_prev) || (Hwrite != hwrite_prev));

        assign error = addr_phase && (state == ERR_IDLE) &&
                       (misaligned || oversize || seq_after_idle || seq_mismatch);

        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                begin
                        htrans_prev <= ahb_pkg::IDLE;
                        hsize_prev  <= '0;
                        hwrite_prev <= 1'b0;
                end
                else
                begin
                        htrans_prev <= Htrans;
                        hsize_prev  <= Hsize;
                        hwrite_prev <= Hwrite;
                end
        end

        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                        state <= ERR_IDLE;
                else
                        state <= state_nxt;
        end

        always_comb
        begin
                case (state)
                ERR_IDLE:
                        state_nxt = error ? ERR_FIRST : ERR_IDLE;
                ERR_FIRST:
                        state_nxt = ERR_SECOND;
                default:
                        state_nxt = ERR_IDLE;
                endcase
        end

        assign Hresp     = (state == ERR_IDLE) ? ahb_pkg::OKAY : ahb_pkg::ERROR;
        assign err_stall = (state == ERR_FIRST);

        // two-cycle response never stretched by a later fault
        a_err_two_cycles: assert property (@(posedge Hclk) disable iff (!Hresetn)
                (Hresp == ahb_pkg::ERROR) [*2] |=> (Hresp == ahb_pkg::OKAY));

endmodule

/* logic/ahb_bridge_front.sv */
`include "bridge_macros.svh"

module ahb_bridge_front
(
        input  logic                            Hclk,
        input  logic                            Hresetn,
        input  ahb_pkg::htrans_t                Htrans,
        input  ahb_pkg::hsize_t                 Hsize,
        input  ahb_pkg::word_t                  Haddr,
        input  logic                            Hwrite,
        input  ahb_pkg::word_t                  Hwdata,
        input  logic                            Hreadyin,
        input  logic                            Hreadyout_in,
        output ahb_pkg::hresp_t                 Hresp,
        output logic                            Hreadyout,
        output bridge_cfg_pkg::slave_sel_t      Pselx_out,
        output logic                            valid,
        output ahb_pkg::word_t                  config_reg_data
);

        ahb_pkg::word_t [`SLAVES-1:0]   base;
        ahb_pkg::word_t [`SLAVES-1:0]   len;
        logic                           err_stall;
        logic                           cfg_wr;
        logic                           active;

        assign cfg_wr = Hwrite && (Haddr <= `CFG_TOP);     // stays local and never goes to APB
        assign active = (Htrans == ahb_pkg::NONSEQ) || (Htrans == ahb_pkg::SEQ);

        // error cycles first then config writes then the APB side's ready
        assign Hreadyout = (Hresp == ahb_pkg::ERROR) ? !err_stall : (cfg_wr || Hreadyout_in);

        assign valid = Hreadyin && (Hresp != ahb_pkg::ERROR) && active && !cfg_wr;

        cfg_regfile i_cfg_regfile
        (
                .Hclk            (Hclk),
                .Hresetn         (Hresetn),
                .Htrans          (Htrans),
                .Hreadyin        (Hreadyin),
                .Hwrite          (Hwrite),
                .Haddr           (Haddr),
                .Hwdata          (Hwdata),
                .Hresp           (Hresp),
                .base            (base),
                .len             (len),
                .config_reg_data (config_reg_data)
        );

        slave_decoder i_slave_decoder
        (
                .Haddr     (Haddr),
                .base      (base),
                .len       (len),
                .Pselx_out (Pselx_out)
        );

        transfer_checker i_transfer_checker
        (
                .Hclk      (Hclk),
                .Hresetn   (Hresetn),
                .Htrans    (Htrans),
                .Hsize     (Hsize),
                .Hwrite    (Hwrite),
                .Haddr     (Haddr),
                .Hreadyin  (Hreadyin),
                .Hresp     (Hresp),
                .err_stall (err_stall)
        );

endmodule

/* tb/clk_gen.sv */
module clk_gen
(
        output logic    Hclk,
        output logic    Hresetn
);

        initial
        begin
                Hclk    = 1'b0;
                Hresetn = 1'b0;
                repeat (3)
                        @(negedge Hclk);
                Hresetn = 1'b1;         // released on a falling edge
        end

        always #20 Hclk = ~Hclk;        // period 40

endmodule

/* tb/tb_top.sv */
`include "bridge_macros.svh"

module tb_top;

        localparam int CYCLE_LIMIT = 2000;      // twice 5 tests of up to 200 cycles

        logic                           Hclk;
        logic                           Hresetn;
        ahb_pkg::htrans_t               Htrans;
        ahb_pkg::hsize_t                Hsize;
        ahb_pkg::word_t                 Haddr;
        logic                           Hwrite;
        ahb_pkg::word_t                 Hwdata;
        logic                           Hreadyin;
        logic                           Hreadyout_in;
        ahb_pkg::hresp_t                Hresp;
        logic                           Hreadyout;
        bridge_cfg_pkg::slave_sel_t     Pselx_out;
        logic                           valid;
        ahb_pkg::word_t                 config_reg_data;

        ahb_pkg::word_t                 shadow_reg [0:`CFG_TOP];       // expected config map
        logic [15:0]                    lfsr_state;
        int                             cycle_count;
        int                             check_count;
        int                             err_count;
        int                             err_mark;
        int                             tests_failing;

        clk_gen i_clk_gen
        (
                .Hclk    (Hclk),
                .Hresetn (Hresetn)
        );

        ahb_bridge_front i_ahb_bridge_front (.*);

        // x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
        function automatic logic lfsr_step();
                logic fb;
                fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
                lfsr_state = {lfsr_state[14:0], fb};
                return fb;
        endfunction

        function automatic ahb_pkg::word_t rand_word();
                ahb_pkg::word_t w;
                w = '0;
                for (int b = 0; b < `WIDTH; b++)
                        w = {w[`WIDTH-2:0], lfsr_step()};
                return w;
        endfunction

        function automatic ahb_pkg::word_t reset_value(input int addr);
                case (addr)
                1:       return `SLAVE1_BASE;
                3:       return `SLAVE2_BASE;
                5:       return `SLAVE3_BASE;
                7:       return `SLAVE4_BASE;
                2, 4, 6, 8:
                         return `SLAVE_LEN;
                default: return '0;     // address 0 and outside the map
                endcase
        endfunction

        // base <= addr < base + len with carry kept
        function automatic bridge_cfg_pkg::slave_sel_t expect_sel(input ahb_pkg::word_t addr);
                bridge_cfg_pkg::slave_sel_t     sel;
                logic [`WIDTH:0]                lo;
                logic [`WIDTH:0]                hi;
                sel = '0;
                for (int i = 0; i < `SLAVES; i++)
                begin
                        lo     = {1'b0, shadow_reg[2 * i + 1]};
                        hi     = lo + {1'b0, shadow_reg[2 * i + 2]};
                        sel[i] = ({1'b0, addr} >= lo) && ({1'b0, addr} < hi);
                end
                return sel;
        endfunction

        task automatic record_check(input logic ok, input string name, input ahb_pkg::word_t got,
                                    input ahb_pkg::word_t exp);
                check_count++;
                if (!ok)
                begin
                        err_count++;
                        $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
                end
        endtask

        task automatic check_word(input string name, input ahb_pkg::word_t got,
                                  input ahb_pkg::word_t exp);
                record_check(got === exp, name, got, exp);
        endtask

        task automatic check_resp(input string name, input ahb_pkg::hresp_t got,
                                  input ahb_pkg::hresp_t exp);
                record_check(got === exp, name, ahb_pkg::word_t'(got), ahb_pkg::word_t'(exp));
        endtask

        task automatic check_sel(input string name, input bridge_cfg_pkg::slave_sel_t got,
                                 input bridge_cfg_pkg::slave_sel_t exp);
                record_check(got === exp, name, ahb_pkg::word_t'(got), ahb_pkg::word_t'(exp));
        endtask

        task automatic check_bit(input string name, input logic got, input logic exp);
                record_check(got === exp, name, ahb_pkg::word_t'(got), ahb_pkg::word_t'(exp));
        endtask

        // one address phase with outputs sampled a quarter period later
        task automatic drive_addr(input ahb_pkg::htrans_t trans, input ahb_pkg::word_t addr,
                                  input ahb_pkg::hsize_t size, input logic write);
                @(negedge Hclk);
                Htrans   = trans;
                Haddr    = addr;
                Hsize    = size;
                Hwrite   = write;
                Hreadyin = 1'b1;
                #10;
        endtask

        task automatic idle_cycle(input ahb_pkg::word_t wdata);
                @(negedge Hclk);
                Htrans = ahb_pkg::IDLE;
                Hwrite = 1'b0;
                Hwdata = wdata;         // data phase of whatever came before
                #10;
        endtask

        task automatic ahb_write(input ahb_pkg::word_t addr, input ahb_pkg::word_t data);
                drive_addr(ahb_pkg::NONSEQ, addr, 3'd2, 1'b1);
                check_bit("valid", valid, 1'b0);
                check_bit("Hreadyout", Hreadyout, 1'b1);
                idle_cycle(data);
                check_resp("Hresp", Hresp, ahb_pkg::OKAY);
                if (addr >= 1 && addr <= `CFG_TOP)
                        shadow_reg[addr] = data;
        endtask

        task automatic ahb_read(input ahb_pkg::word_t addr, output ahb_pkg::word_t data);
                drive_addr(ahb_pkg::NONSEQ, addr, 3'd2, 1'b0);
                idle_cycle(Hwdata);
                check_resp("Hresp", Hresp, ahb_pkg::OKAY);
                data = config_reg_data;
        endtask

        task automatic probe_decode(input ahb_pkg::word_t addr);
                drive_addr(ahb_pkg::NONSEQ, addr, 3'd0, 1'b0);   // byte size is never misaligned
                check_sel("Pselx_out", Pselx_out, expect_sel(addr));
                check_bit("valid", valid, 1'b1);
                check_bit("Hreadyout", Hreadyout, Hreadyout_in);
        endtask

        // called right after the offending address phase
        task automatic check_error_seq();
                drive_addr(ahb_pkg::NONSEQ, 32'h8000_0010, 3'd2, 1'b0);
                check_resp("Hresp", Hresp, ahb_pkg::ERROR);
                check_bit("Hreadyout", Hreadyout, 1'b0);
                check_bit("valid", valid, 1'b0);
                drive_addr(ahb_pkg::NONSEQ, 32'h8000_0010, 3'd2, 1'b0);
                check_resp("Hresp", Hresp, ahb_pkg::ERROR);
                check_bit("Hreadyout", Hreadyout, 1'b1);
                check_bit("valid", valid, 1'b0);
                idle_cycle(Hwdata);
                check_resp("Hresp", Hresp, ahb_pkg::OKAY);
        endtask

        task automatic test_reset_defaults();
                ahb_pkg::word_t rd;
                idle_cycle(Hwdata);
                check_resp("Hresp", Hresp, ahb_pkg::OKAY);
                check_bit("Hreadyout", Hreadyout, 1'b1);
                check_word("config_reg_data", config_reg_data, '0);
                for (int a = 1; a <= `CFG_TOP; a++)
                begin
                        ahb_read(a, rd);
                        check_word("config_reg_data", rd, reset_value(a));
                        check_bit("Hreadyout", Hreadyout, 1'b1);
                end
        endtask

        task automatic test_config_rw();
                ahb_pkg::word_t rd;
                for (int a = 0; a <= `CFG_TOP; a++)
                        ahb_write(a, rand_word());
                for (int a = 0; a <= `CFG_TOP; a++)
                begin
                        ahb_read(a, rd);
                        check_word("config_reg_data", rd, shadow_reg[a]);
                end
                ahb_read(32'h0000_0040, rd);            // past the config window
                check_word("config_reg_data", rd, '0);
        endtask

        task automatic test_decode();
                ahb_write(1, `SLAVE1_BASE);
                ahb_write(2, `SLAVE_LEN);
                ahb_write(3, 32'h9000_0000);            // slave 2 moved
                ahb_write(4, 32'h0000_0100);
                for (int a = 5; a <= `CFG_TOP; a++)
                        ahb_write(a, reset_value(a));
                probe_decode(32'h9000_0000);
                probe_decode(32'h9000_00FF);
                probe_decode(32'h9000_0100);
                probe_decode(`SLAVE2_BASE);
                probe_decode(32'h8000_0010);
                probe_decode(32'h8800_03FE);
                probe_decode(32'h8C00_03FF);            // one past slave 4
                @(negedge Hclk);
                Hreadyout_in = 1'b0;    // APB side stalls while the master holds
                repeat (3)
                        probe_decode(32'h8800_0100);
                @(negedge Hclk);
                Hreadyout_in = 1'b1;
                probe_decode(32'h8800_0100);
                idle_cycle(Hwdata);
        endtask

        task automatic test_align_error();
                drive_addr(ahb_pkg::NONSEQ, 32'h8000_0002, 3'd2, 1'b0);
                check_resp("Hresp", Hresp, ahb_pkg::OKAY);
                check_error_seq();
        endtask

        task automatic test_protocol_errors();
                ahb_pkg::word_t rd;
                idle_cycle(~shadow_reg[3]);
                drive_addr(ahb_pkg::SEQ, 32'd3, 3'd2, 1'b1);    // config write that must not land
                check_error_seq();
                ahb_read(3, rd);
                check_word("config_reg_data", rd, shadow_reg[3]);
                drive_addr(ahb_pkg::NONSEQ, 32'h8000_0020, 3'd2, 1'b0);
                drive_addr(ahb_pkg::SEQ, 32'h8000_0024, 3'd2, 1'b1);
                check_error_seq();
                drive_addr(ahb_pkg::NONSEQ, 32'h8000_0040, 3'd3, 1'b0);
                check_error_seq();
        endtask

        task automatic end_test(input int num, input string name);
                if (err_count == err_mark)
                        $display("[%0d] %s: ok", num, name);
                else
                begin
                        tests_failing++;
                        $display("[%0d] %s: %0d errors", num, name, err_count - err_mark);
                end
                err_mark = err_count;
        endtask

        always @(posedge Hclk)
        begin
                cycle_count = cycle_count + 1;
                if (cycle_count >= CYCLE_LIMIT)
                begin
                        $display("timeout: run stopped after %0d cycles", cycle_count);
                        $display("test failed");
                        $finish;
                end
        end

        initial
        begin
                Htrans        = ahb_pkg::IDLE;
                Hsize         = 3'd0;
                Haddr         = '0;
                Hwrite        = 1'b0;
                Hwdata        = '0;
                Hreadyin      = 1'b1;
                Hreadyout_in  = 1'b1;
                lfsr_state    = 16'd47721;
                cycle_count   = 0;
                check_count   = 0;
                err_count     = 0;
                err_mark      = 0;
                tests_failing = 0;
                for (int a = 0; a <= `CFG_TOP; a++)
                        shadow_reg[a] = reset_value(a);
                @(posedge Hresetn);
                test_reset_defaults();
                end_test(1, "reset defaults");
                test_config_rw();
                end_test(2, "config write and readback");
                test_decode();
                end_test(3, "slave decode");
                test_align_error();
                end_test(4, "alignment error");
                test_protocol_errors();
                end_test(5, "protocol errors");
                $display("summary: 5 tests, %0d failing, %0d checks, %0d errors",
                         tests_failing, check_count, err_count);
                if (err_count == 0)
                        $display("test passed");
                else
                        $display("test failed");
                $finish;
        end

endmodule

/* tb.f */
+incdir+logic
logic/ahb_pkg.sv
logic/bridge_cfg_pkg.sv
logic/cfg_regfile.sv
logic/slave_decoder.sv
logic/transfer_checker.sv
logic/ahb_bridge_front.sv
tb/clk_gen.sv
tb/tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_top -f tb.f
./obj_dir/Vtb_top | tee sim.log
if grep -q "test failed" sim.log
then
        echo "simulation reported a failure"
        exit 1
fi
if ! grep -q "test passed" sim.log
then
        echo "simulation ended without a result"
        exit 1
fi
exit 0
